// File: burst_serializer.sv
`timescale 1ns/1ps

// cuts each 128-bit memory burst into four link words, low word first
module burst_serializer (
  input  logic                    clk125,
  input  logic                    rst_n,
  // bursts read back from the waveform memory
  input  readout_pkg::mem_burst_t mem_tdata,
  input  logic                    mem_tvalid,
  input  logic                    mem_tlast,
  output logic                    mem_tready,
  // link words toward the multiplexer
  output readout_pkg::link_word_t w_tdata,
  output logic                    w_tvalid,
  output logic                    w_tlast,
  input  logic                    w_tready
);

  readout_pkg::mem_burst_t burst_q;  // held burst
  logic                    last_q;   // burst closes a packet
  readout_pkg::word_idx_t  idx_q;    // word now presented
  logic                    held_q;   // a burst is loaded

  logic last_word;  // presenting the top word
  logic w_xfer;     // link word taken this cycle
  logic mem_xfer;   // new burst taken this cycle

  assign last_word = (idx_q == readout_pkg::word_idx_t'(readout_pkg::WORDS_PER_BURST - 1));
  assign w_xfer    = w_tvalid & w_tready;

  // free slot, or the top word leaves now -> no bubble between bursts
  assign mem_tready = ~held_q | (w_xfer & last_word);
  assign mem_xfer   = mem_tvalid & mem_tready;

  assign w_tvalid = held_q;
  assign w_tdata  = burst_q[idx_q * $bits(readout_pkg::link_word_t) +: $bits(readout_pkg::link_word_t)];
  assign w_tlast  = last_q & last_word;  // only word 3 of a closing burst

  ////////////////////////////////////////////////////////////////////////////
  // control

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      held_q <= 1'b0;
      idx_q  <= '0;
    end else if (mem_xfer) begin
      held_q <= 1'b1;      // word 0 visible next cycle
      idx_q  <= '0;
    end else if (w_xfer) begin
      if (last_word) held_q <= 1'b0;  // burst used up
      else           idx_q  <= idx_q + 1'b1;
    end
  end

  // payload capture
  always_ff @(posedge clk125) begin
    if (mem_xfer) begin
      burst_q <= mem_tdata;
      last_q  <= mem_tlast;
    end
  end

endmodule

// File: command_reply_fifo.sv
`timescale 1ns/1ps

// small queue between the command processor and the link multiplexer
module command_reply_fifo (
  input  logic                   clk125,
  input  logic                   rst_n,
  // replies from the command processor
  input  readout_pkg::link_word_t cmd_tdata,
  input  logic                   cmd_tvalid,
  input  logic                   cmd_tlast,
  output logic                   cmd_tready,
  // head of queue toward the multiplexer
  output readout_pkg::link_word_t q_tdata,
  output logic                   q_tvalid,
  output logic                   q_tlast,
  input  logic                   q_tready
);

  // storage, word and its last flag side by side
  readout_pkg::link_word_t mem_data [readout_pkg::CMD_FIFO_DEPTH];
  logic                    mem_last [readout_pkg::CMD_FIFO_DEPTH];

  readout_pkg::cmd_ptr_t wr_ptr;  // next free slot
  readout_pkg::cmd_ptr_t rd_ptr;  // current head
  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  ////////////////////////////////////////////////////////////////////////////
  // status from the pointers

  // same slot, wrap bits differ -> every slot taken
  assign full  = (wr_ptr[$bits(readout_pkg::cmd_ptr_t)-1] != rd_ptr[$bits(readout_pkg::cmd_ptr_t)-1])
              && (wr_ptr[$bits(readout_pkg::cmd_ptr_t)-2:0]
                  == rd_ptr[$bits(readout_pkg::cmd_ptr_t)-2:0]);
  assign empty = (wr_ptr == rd_ptr);  // pointers equal including wrap bit

  assign cmd_tready = ~full;              // only low with all slots in use
  assign q_tvalid   = ~empty;
  assign wr_en      = cmd_tvalid & ~full;
  assign rd_en      = q_tready & ~empty;  // read and write may share a cycle

  // head is read straight from the array
  assign q_tdata = mem_data[rd_ptr[$bits(readout_pkg::cmd_ptr_t)-2:0]];
  assign q_tlast = mem_last[rd_ptr[$bits(readout_pkg::cmd_ptr_t)-2:0]];

  ////////////////////////////////////////////////////////////////////////////
  // pointers

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // wraps through the extra bit
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // array write, word shows at the head one cycle later
  always_ff @(posedge clk125) begin
    if (wr_en) begin
      mem_data[wr_ptr[$bits(readout_pkg::cmd_ptr_t)-2:0]] <= cmd_tdata;
      mem_last[wr_ptr[$bits(readout_pkg::cmd_ptr_t)-2:0]] <= cmd_tlast;
    end
  end

endmodule

// File: link_tx_mux.sv
`timescale 1ns/1ps

// merges command replies and memory words onto the link, one packet at a time
module link_tx_mux (
  input  logic                    clk125,
  input  logic                    rst_n,
  input  logic                    readout_pause,  // async level from the master
  // command reply source
  input  readout_pkg::link_word_t q_tdata,
  input  logic                    q_tvalid,
  input  logic                    q_tlast,
  output logic                    q_tready,
  // memory word source
  input  readout_pkg::link_word_t w_tdata,
  input  logic                    w_tvalid,
  input  logic                    w_tlast,
  output logic                    w_tready,
  // link stream
  output readout_pkg::link_word_t tx_tdata,
  output logic                    tx_tvalid,
  output logic                    tx_tlast,
  input  logic                    tx_tready
);

  logic pause_meta;  // first sync stage
  logic pause_s;     // synchronized pause

  readout_pkg::tx_src_e src_q;  // registered selection
  readout_pkg::tx_src_e src_d;
  readout_pkg::tx_src_e sel;    // source routed this cycle

  logic src_valid;  // selected source has a word
  logic go;         // link may take words now

  ////////////////////////////////////////////////////////////////////////////
  // pause synchronizer, comes out of reset paused

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      pause_meta <= 1'b1;
      pause_s    <= 1'b1;
    end else begin
      pause_meta <= readout_pause;
      pause_s    <= pause_meta;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // source choice

  always_comb begin
    sel = src_q;
    if (src_q == readout_pkg::src_idle) begin
      if (q_tvalid)      sel = readout_pkg::src_cmd;  // replies win at a boundary
      else if (w_tvalid) sel = readout_pkg::src_mem;
    end
  end

  // routing follows sel in the same cycle
  always_comb begin
    case (sel)
      readout_pkg::src_cmd: src_valid = q_tvalid;
      readout_pkg::src_mem: src_valid = w_tvalid;
      default:              src_valid = 1'b0;
    endcase
  end

  assign go        = ~pause_s;
  assign tx_tvalid = src_valid & go;
  assign tx_tdata  = (sel == readout_pkg::src_mem) ? w_tdata : q_tdata;
  assign tx_tlast  = (sel == readout_pkg::src_mem) ? w_tlast : q_tlast;

  // ready only back to the routed source
  assign q_tready = (sel == readout_pkg::src_cmd) & tx_tready & go;
  assign w_tready = (sel == readout_pkg::src_mem) & tx_tready & go;

  // free again after a last word; a word on offer pins the choice so data holds
  always_comb begin
    src_d = src_q;
    if (tx_tvalid && tx_tready && tx_tlast) src_d = readout_pkg::src_idle;
    else if (tx_tvalid)                     src_d = sel;
  end

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) src_q <= readout_pkg::src_idle;
    else        src_q <= src_d;
  end

endmodule

// File: project.f
readout_pkg.sv
command_reply_fifo.sv
burst_serializer.sv
link_tx_mux.sv
readout_link_top.sv
readout_link_assert.sv
tb_readout_link.sv

// File: readout_link_assert.sv
`timescale 1ns/1ps

// stream protocol checks on the link multiplexer, bound in below
module readout_link_assert (
  input logic                    clk125,
  input logic                    rst_n,
  input logic                    readout_pause,
  input logic                    q_tvalid,
  input logic                    q_tlast,
  input logic                    q_tready,
  input logic                    w_tvalid,
  input logic                    w_tlast,
  input logic                    w_tready,
  input readout_pkg::link_word_t tx_tdata,
  input logic                    tx_tvalid,
  input logic                    tx_tlast,
  input logic                    tx_tready
);

  int   err_count = 0;  // read by the testbench at the end of the run
  logic cmd_open;       // command packet started, last word not yet sent
  logic mem_open;       // same for memory packets

  wire cmd_xfer = q_tvalid & q_tready;
  wire mem_xfer = w_tvalid & w_tready;

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      cmd_open <= 1'b0;
      mem_open <= 1'b0;
    end else begin
      if (cmd_xfer) cmd_open <= ~q_tlast;
      if (mem_xfer) mem_open <= ~w_tlast;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // packets never interleave

  a_cmd_whole: assert property (@(posedge clk125) disable iff (!rst_n) cmd_open |-> !mem_xfer)
    else begin err_count++; $error("memory word sent inside an open command packet"); end
  a_mem_whole: assert property (@(posedge clk125) disable iff (!rst_n) mem_open |-> !cmd_xfer)
    else begin err_count++; $error("command word sent inside an open memory packet"); end

  // 2 sync flops, so three samples high must have closed the gate
  a_pause: assert property (@(posedge clk125) disable iff (!rst_n)
                            readout_pause [*3] |-> !tx_tvalid)
    else begin err_count++; $error("tx_tvalid high while readout_pause held"); end

  // offered word holds until taken (pause may withdraw it)
  a_hold: assert property (@(posedge clk125) disable iff (!rst_n)
                           tx_tvalid && !tx_tready |=>
                           !tx_tvalid || ($stable(tx_tdata) && $stable(tx_tlast)))
    else begin err_count++; $error("tx_tdata or tx_tlast changed under back-pressure"); end

  a_reset: assert property (@(posedge clk125) $rose(rst_n) |-> !tx_tvalid)
    else begin err_count++; $error("tx_tvalid high in the first cycle after reset"); end

endmodule

bind link_tx_mux readout_link_assert u_assert (.*);

// File: readout_link_top.sv
`timescale 1ns/1ps

// transmit side of the channel link: reply queue + burst serializer + mux
module readout_link_top (
  input  logic                    clk125,
  input  logic                    rst_n,
  // command replies
  input  readout_pkg::link_word_t cmd_tdata,
  input  logic                    cmd_tvalid,
  input  logic                    cmd_tlast,
  output logic                    cmd_tready,
  // memory readout bursts
  input  readout_pkg::mem_burst_t mem_tdata,
  input  logic                    mem_tvalid,
  input  logic                    mem_tlast,
  output logic                    mem_tready,
  input  logic                    readout_pause,  // from the master, not synchronized
  // link to the master
  output readout_pkg::link_word_t tx_tdata,
  output logic                    tx_tvalid,
  output logic                    tx_tlast,
  input  logic                    tx_tready
);

  // queue head -> mux
  readout_pkg::link_word_t q_tdata;
  logic q_tvalid;
  logic q_tlast;
  logic q_tready;

  // serializer -> mux
  readout_pkg::link_word_t w_tdata;
  logic w_tvalid;
  logic w_tlast;
  logic w_tready;

  command_reply_fifo u_cmd_fifo (
    .clk125     (clk125),
    .rst_n      (rst_n),
    .cmd_tdata  (cmd_tdata),
    .cmd_tvalid (cmd_tvalid),
    .cmd_tlast  (cmd_tlast),
    .cmd_tready (cmd_tready),
    .q_tdata    (q_tdata),
    .q_tvalid   (q_tvalid),
    .q_tlast    (q_tlast),
    .q_tready   (q_tready)
  );

  burst_serializer u_serializer (
    .clk125     (clk125),
    .rst_n      (rst_n),
    .mem_tdata  (mem_tdata),
    .mem_tvalid (mem_tvalid),
    .mem_tlast  (mem_tlast),
    .mem_tready (mem_tready),
    .w_tdata    (w_tdata),
    .w_tvalid   (w_tvalid),
    .w_tlast    (w_tlast),
    .w_tready   (w_tready)
  );

  link_tx_mux u_mux (
    .clk125        (clk125),
    .rst_n         (rst_n),
    .readout_pause (readout_pause),
    .q_tdata       (q_tdata),
    .q_tvalid      (q_tvalid),
    .q_tlast       (q_tlast),
    .q_tready      (q_tready),
    .w_tdata       (w_tdata),
    .w_tvalid      (w_tvalid),
    .w_tlast       (w_tlast),
    .w_tready      (w_tready),
    .tx_tdata      (tx_tdata),
    .tx_tvalid     (tx_tvalid),
    .tx_tlast      (tx_tlast),
    .tx_tready     (tx_tready)
  );

endmodule

// File: readout_pkg.sv
// shared types and sizes for the link transmit path

package readout_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // stream widths

  typedef logic [31:0]  link_word_t;  // one word on the serial link
  typedef logic [127:0] mem_burst_t;  // one burst from the waveform memory

  localparam int WORDS_PER_BURST = 4; // link words cut from one burst
  typedef logic [1:0] word_idx_t;     // word position inside a burst

  ////////////////////////////////////////////////////////////////////////////
  // command reply buffer

  localparam int CMD_FIFO_DEPTH = 4;  // reply words held before cmd_tready drops
  typedef logic [2:0] cmd_ptr_t;      // index bits plus one wrap bit

  ////////////////////////////////////////////////////////////////////////////
  // link multiplexer source select

  typedef enum logic [1:0] {
    src_idle,  // between packets, free to choose
    src_cmd,   // locked to command replies
    src_mem    // locked to memory readout
  } tx_src_e;

endpackage

// File: tb_readout_link.sv
`timescale 1ns/1ps

module tb_readout_link;

  logic                    clk125;
  logic                    rst_n;
  readout_pkg::link_word_t cmd_tdata;
  logic                    cmd_tvalid;
  logic                    cmd_tlast;
  logic                    cmd_tready;
  readout_pkg::mem_burst_t mem_tdata;
  logic                    mem_tvalid;
  logic                    mem_tlast;
  logic                    mem_tready;
  logic                    readout_pause;
  readout_pkg::link_word_t tx_tdata;
  logic                    tx_tvalid;
  logic                    tx_tlast;
  logic                    tx_tready;

  logic [31:0] lcg_state = 32'd65560;
  logic [32:0] cmd_q [$];  // {last, word} owed on the link
  logic [32:0] mem_q [$];
  logic pkt_open;          // a packet is running on tx
  logic pkt_is_cmd;
  logic cmd_first;         // next packet must be a command reply
  logic gap_check;         // no idle cycle allowed inside a memory packet
  logic rand_ready;        // tx_tready from the lcg, else held high
  int   cmd_held;          // reply words sitting in the queue
  int   mem_held;          // burst words sitting in the serializer
  int   errors;
  int   words;
  int   test_len [6] = '{60, 60, 200, 60, 100, 300};  // rough cycles per test

  readout_link_top u_dut (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int total_errors();
    return errors + u_dut.u_mux.u_assert.err_count;  // own checks plus assertions
  endfunction

  initial begin
    clk125 = 1'b0;
    forever #4 clk125 = ~clk125;
  end

  initial begin
    tx_tready = 1'b1;
    forever begin
      @(posedge clk125);
      #1 tx_tready = rand_ready ? (lcg_next() >= 32'h6000_0000) : 1'b1;  // ~60 % high
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // expected words, taken where the inputs are accepted

  always @(negedge clk125) begin
    if (rst_n && cmd_tvalid && cmd_tready) cmd_q.push_back({cmd_tlast, cmd_tdata});
    if (rst_n && mem_tvalid && mem_tready)
      for (int i = 0; i < readout_pkg::WORDS_PER_BURST; i++)  // low word leaves first
        mem_q.push_back({mem_tlast && (i == readout_pkg::WORDS_PER_BURST - 1),
                         mem_tdata[i*32 +: 32]});
  end

  // ready back to the sources, from the words each block still holds
  always @(negedge clk125) begin
    logic tx_cmd;  // reply word leaves on the link
    logic tx_mem;  // memory word leaves on the link
    tx_cmd = tx_tvalid && tx_tready && tx_tdata[31];
    tx_mem = tx_tvalid && tx_tready && !tx_tdata[31];
    if (!rst_n) begin
      cmd_held = 0;
      mem_held = 0;
    end else begin
      if (cmd_tready !== (cmd_held < readout_pkg::CMD_FIFO_DEPTH)) begin
        errors++;
        $display("mismatch cmd_tready: expected %h, got %h",
                 cmd_held < readout_pkg::CMD_FIFO_DEPTH, cmd_tready);
      end
      // free slot, or the top word of the held burst leaves now
      if (mem_tready !== (mem_held == 0 || (mem_held == 1 && tx_mem))) begin
        errors++;
        $display("mismatch mem_tready: expected %h, got %h",
                 mem_held == 0 || (mem_held == 1 && tx_mem), mem_tready);
      end
      if (cmd_tvalid && cmd_tready) cmd_held++;
      if (tx_cmd)                   cmd_held--;
      if (mem_tvalid && mem_tready) mem_held += readout_pkg::WORDS_PER_BURST;
      if (tx_mem)                   mem_held--;
    end
  end

  // link monitor, pops only the queue that opened the packet
  always @(negedge clk125) begin
    logic [32:0] want;
    if (rst_n && tx_tvalid && tx_tready) begin
      if (!pkt_open) begin
        pkt_is_cmd = tx_tdata[31];  // replies carry bit 31 set
        if (cmd_first && !pkt_is_cmd) begin
          errors++;
          $display("memory packet went out ahead of a waiting command packet");
        end
        cmd_first = 1'b0;
      end
      pkt_open = !tx_tlast;
      if ((pkt_is_cmd ? cmd_q.size() : mem_q.size()) == 0) begin
        errors++;
        $display("link word %h sent while none was expected from that source", tx_tdata);
      end else begin
        want = pkt_is_cmd ? cmd_q.pop_front() : mem_q.pop_front();
        words++;
        if (tx_tdata !== want[31:0]) begin
          errors++;
          $display("mismatch tx_tdata: expected %h, got %h", want[31:0], tx_tdata);
        end
        if (tx_tlast !== want[32]) begin
          errors++;
          $display("mismatch tx_tlast: expected %h, got %h", want[32], tx_tlast);
        end
      end
    end else if (rst_n && pkt_open && gap_check && !pkt_is_cmd && !tx_tvalid) begin
      errors++;
      $display("idle cycle inside a memory packet");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // drivers, entered 1 ns after a rising edge

  task automatic send_cmd_packet(input int len);
    for (int i = 0; i < len; i++) begin
      cmd_tdata  = lcg_next() | 32'h8000_0000;
      cmd_tvalid = 1'b1;
      cmd_tlast  = (i == len - 1);
      do @(negedge clk125); while (!cmd_tready);
      @(posedge clk125);
      #1;
    end
    cmd_tvalid = 1'b0;
  endtask

  task automatic send_burst_packet(input int bursts);
    for (int b = 0; b < bursts; b++) begin
      for (int i = 0; i < readout_pkg::WORDS_PER_BURST; i++)
        mem_tdata[i*32 +: 32] = lcg_next() & 32'h7fff_ffff;  // bit 31 clear marks memory
      mem_tvalid = 1'b1;
      mem_tlast  = (b == bursts - 1);
      do @(negedge clk125); while (!mem_tready);
      @(posedge clk125);
      #1;
    end
    mem_tvalid = 1'b0;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    do begin
      @(negedge clk125);
      n++;
    end while ((cmd_q.size() != 0 || mem_q.size() != 0 || pkt_open) && n < 400);
    if (cmd_q.size() != 0 || mem_q.size() != 0 || pkt_open) begin
      errors++;
      $display("link did not deliver all queued words within 400 cycles");
    end
    @(posedge clk125);
    #1;
  endtask

  task automatic report_test(input int num, input string name, input int err0);
    $display("test %0d %s done, %0d errors", num, name, total_errors() - err0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests

  initial begin
    int e0;
    rst_n         = 1'b0;
    cmd_tdata     = '0;
    cmd_tvalid    = 1'b0;
    cmd_tlast     = 1'b0;
    mem_tdata     = '0;
    mem_tvalid    = 1'b0;
    mem_tlast     = 1'b0;
    readout_pause = 1'b0;
    rand_ready    = 1'b0;
    pkt_open      = 1'b0;
    pkt_is_cmd    = 1'b0;
    cmd_first     = 1'b0;
    gap_check     = 1'b0;
    errors        = 0;
    words         = 0;
    repeat (10) @(posedge clk125);
    #1 rst_n = 1'b1;

    e0 = total_errors();
    for (int p = 0; p < 10; p++) send_cmd_packet(p % 4 + 1);
    wait_drained();
    report_test(1, "command packets", e0);

    e0 = total_errors();
    gap_check = 1'b1;
    for (int p = 0; p < 4; p++) send_burst_packet(p % 3 + 1);
    wait_drained();
    gap_check = 1'b0;
    report_test(2, "memory bursts", e0);

    e0 = total_errors();
    rand_ready = 1'b1;
    fork
      for (int p = 0; p < 8; p++) send_cmd_packet((lcg_next() >> 20) % 4 + 1);
      for (int p = 0; p < 5; p++) send_burst_packet((lcg_next() >> 20) % 2 + 1);
    join
    wait_drained();
    rand_ready = 1'b0;
    report_test(3, "no interleave", e0);

    // both sources loaded behind the pause gate, then released together
    e0 = total_errors();
    readout_pause = 1'b1;
    repeat (4) @(posedge clk125);
    #1;
    fork
      send_burst_packet(2);
      begin
        send_cmd_packet(3);
        repeat (2) @(posedge clk125);
        #1 cmd_first = 1'b1;
        readout_pause = 1'b0;
      end
    join
    wait_drained();
    report_test(4, "reply priority", e0);

    e0 = total_errors();
    readout_pause = 1'b1;
    fork
      for (int p = 0; p < 2; p++) send_cmd_packet(2);
      send_burst_packet(3);
      begin
        repeat (24) @(posedge clk125);
        #1 readout_pause = 1'b0;
      end
    join
    wait_drained();
    report_test(5, "readout pause", e0);

    e0 = total_errors();
    rand_ready = 1'b1;
    fork
      for (int p = 0; p < 12; p++) send_cmd_packet((lcg_next() >> 20) % 4 + 1);
      for (int p = 0; p < 6; p++) send_burst_packet((lcg_next() >> 20) % 3 + 1);
    join
    wait_drained();
    rand_ready = 1'b0;
    report_test(6, "random back-pressure", e0);

    $display("6 tests run, %0d link words checked, %0d errors", words, total_errors());
    if (total_errors() == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // watchdog, four times the summed test lengths
  initial begin
    int limit;
    limit = 0;
    foreach (test_len[i]) limit += test_len[i];
    repeat (limit * 4) @(posedge clk125);
    $display("watchdog: tests still running after %0d cycles", limit * 4);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
